// ==== files.f ====
+incdir+.
lcd_pkg.sv
lcd_tick.sv
reg_page_text.sv
lcd_sequencer.sv
reg_lcd_top.sv
tb_lcd_checks.sv
tb_reg_lcd.sv

// ==== lcd_pkg.sv ====
//////////////////////////////
// Types shared by the LCD monitor RTL and its testbench.
//////////////////////////////
`default_nettype none

`include "lcd_settings.svh"

package lcd_pkg;

	typedef logic [7:0] lcd_byte_t; // LCD data bus byte

	typedef logic [2:0] page_t; // Page 0 to 4

	typedef logic [3:0] col_t; // Column within a line

	// Register word, whole or by nibble
	typedef union packed
	{
		logic [`LCD_REG_W-1:0] word;
		logic [`LCD_DIGITS-1:0][3:0] nib;
	} reg_word_u;

endpackage

`default_nettype wire

// ==== lcd_sequencer.sv ====
//////////////////////////////
// LCD init and refresh FSM. Steps on tick, one transfer per two
// ticks, and walks the page text by line and column.
//////////////////////////////
`default_nettype none

`include "lcd_settings.svh"

module lcd_sequencer (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               tick,
	input  logic [2:0]         sw,
	input  lcd_pkg::lcd_byte_t char_in,
	input  logic               line_end,
	output lcd_pkg::page_t     page,
	output logic               line,
	output lcd_pkg::col_t      col,
	output logic               lcd_en,
	output logic               lcd_rs,
	output logic               lcd_rw,
	output logic               lcd_on,
	output lcd_pkg::lcd_byte_t lcd_data
);

	import lcd_pkg::*;

	localparam logic [2:0] ph_power = 3'd0;
	localparam logic [2:0] ph_init  = 3'd1;
	localparam logic [2:0] ph_entry = 3'd2;
	localparam logic [2:0] ph_clear = 3'd3; // Clear check
	localparam logic [2:0] ph_home  = 3'd4;
	localparam logic [2:0] ph_text  = 3'd5;
	localparam logic [2:0] ph_line2 = 3'd6;
	localparam logic [2:0] ph_low   = 3'd7; // Enable-low half step

	logic [2:0] phase;
	logic [2:0] nxt;        // Phase after the half step
	logic [2:0] init_idx;
	page_t      sw_page;
	page_t      last_page;
	logic       shown_valid;

	assign lcd_rw  = 1'b0; // Write only
	assign sw_page = (sw < 3'(`LCD_PAGES)) ? page_t'(sw) : page_t'(0);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			phase       <= ph_power;
			nxt         <= ph_init;
			init_idx    <= '0;
			page        <= '0;
			line        <= 1'b0;
			col         <= '0;
			last_page   <= '0;
			shown_valid <= 1'b0;
			lcd_en      <= 1'b0;
			lcd_rs      <= 1'b0;
			lcd_on      <= 1'b0;
			lcd_data    <= '0;
		end
		else if (tick)
		begin
			case (phase)
				ph_power: phase <= ph_init;

				ph_low:
				begin
					lcd_en <= 1'b0;
					lcd_on <= 1'b1;
					if (nxt == ph_text && line_end)
						phase <= line ? ph_entry : ph_line2; // Line text done
					else
						phase <= nxt;
				end

				default:
				begin
					// Every other phase starts a transfer
					lcd_en <= 1'b1;
					lcd_rs <= 1'b0;
					phase  <= ph_low;
					case (phase)
						ph_init:
						begin
							init_idx <= init_idx + 1'b1;
							if (init_idx < 3'd4)
								lcd_data <= `LCD_CMD_FUNC;
							else if (init_idx == 3'd4)
								lcd_data <= `LCD_CMD_OFF;
							else if (init_idx == 3'd5)
								lcd_data <= `LCD_CMD_CLEAR;
							else
								lcd_data <= `LCD_CMD_ON;
							nxt <= (init_idx == 3'd6) ? ph_entry : ph_init;
						end

						ph_entry:
						begin
							lcd_data <= `LCD_CMD_ENTRY;
							page     <= sw_page; // Page fixed for this refresh
							line     <= 1'b0;
							col      <= '0;
							nxt      <= ph_clear;
						end

						ph_clear:
						begin
							if (!shown_valid || page != last_page)
							begin
								lcd_data    <= `LCD_CMD_CLEAR;
								last_page   <= page;
								shown_valid <= 1'b1;
								nxt         <= ph_home;
							end
							else
							begin
								lcd_data <= `LCD_CMD_HOME; // Same page, no clear
								nxt      <= ph_text;
							end
						end

						ph_home:
						begin
							lcd_data <= `LCD_CMD_HOME;
							nxt      <= ph_text;
						end

						ph_line2:
						begin
							lcd_data <= `LCD_CMD_LINE2;
							line     <= 1'b1;
							col      <= '0;
							nxt      <= ph_text;
						end

						default:
						begin
							lcd_rs   <= 1'b1; // Character data
							lcd_data <= char_in;
							col      <= col + 1'b1;
							nxt      <= ph_text;
						end
					endcase
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== lcd_settings.svh ====
//////////////////////////////
// Shared constants for the register LCD monitor:
// HD44780 command bytes, widths and the tick divider.
// Included by the package and every RTL file.
//////////////////////////////
`ifndef LCD_SETTINGS_SVH
`define LCD_SETTINGS_SVH

`define LCD_REG_W      32
`define LCD_DIGITS     8
`define LCD_PAGES      5

`define LCD_CMD_FUNC   8'h38 // 8-bit bus, two lines
`define LCD_CMD_OFF    8'h08
`define LCD_CMD_CLEAR  8'h01
`define LCD_CMD_ON     8'h0C // Display on, no cursor
`define LCD_CMD_ENTRY  8'h06 // Increment, no shift
`define LCD_CMD_HOME   8'h80 // DDRAM address 0x00
`define LCD_CMD_LINE2  8'hC0

`define LCD_TICK_DIV   125000
`define LCD_TICK_W     17

`endif

// ==== lcd_tick.sv ====
//////////////////////////////
// Clock-enable generator for the LCD sequencer.
// tick is high for one clk every tick_div clocks.
//////////////////////////////
`default_nettype none

`include "lcd_settings.svh"

module lcd_tick #(
	parameter int tick_div = `LCD_TICK_DIV
) (
	input  logic clk,
	input  logic rst_n,
	output logic tick
);

	logic [`LCD_TICK_W-1:0] cnt;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			cnt  <= '0;
			tick <= 1'b0;
		end
		else if (cnt == `LCD_TICK_W'(tick_div - 1))
		begin
			cnt  <= '0; // Wrap
			tick <= 1'b1;
		end
		else
		begin
			cnt  <= cnt + 1'b1;
			tick <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== reg_lcd_top.sv ====
//////////////////////////////
// Register LCD monitor top. Shows two processor registers per
// page on a two-line character LCD, page picked by sw.
//////////////////////////////
`default_nettype none

`include "lcd_settings.svh"

module reg_lcd_top #(
	parameter int tick_div = `LCD_TICK_DIV
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [2:0]            sw,
	input  logic [`LCD_REG_W-1:0] mdr,
	input  logic [`LCD_REG_W-1:0] mar,
	input  logic [`LCD_REG_W-1:0] pc,
	input  logic [`LCD_REG_W-1:0] mbr,
	input  logic [`LCD_REG_W-1:0] sp,
	input  logic [`LCD_REG_W-1:0] cpp,
	input  logic [`LCD_REG_W-1:0] lv,
	input  logic [`LCD_REG_W-1:0] tos,
	input  logic [`LCD_REG_W-1:0] opc,
	input  logic [`LCD_REG_W-1:0] h,
	output logic                  lcd_en,
	output logic                  lcd_rs,
	output logic                  lcd_rw,
	output logic                  lcd_on,
	output lcd_pkg::lcd_byte_t    lcd_data
);

	import lcd_pkg::*;

	logic      tick;
	page_t     page;
	logic      line;
	col_t      col;
	lcd_byte_t char_w;
	logic      line_end;

	lcd_tick #(
		.tick_div (tick_div)
	) u_tick (
		.clk   (clk),
		.rst_n (rst_n),
		.tick  (tick)
	);

	lcd_sequencer u_seq (
		.clk      (clk),
		.rst_n    (rst_n),
		.tick     (tick),
		.sw       (sw),
		.char_in  (char_w),
		.line_end (line_end),
		.page     (page),
		.line     (line),
		.col      (col),
		.lcd_en   (lcd_en),
		.lcd_rs   (lcd_rs),
		.lcd_rw   (lcd_rw),
		.lcd_on   (lcd_on),
		.lcd_data (lcd_data)
	);

	reg_page_text u_text (
		.page     (page),
		.line     (line),
		.col      (col),
		.mdr      (mdr),
		.mar      (mar),
		.pc       (pc),
		.mbr      (mbr),
		.sp       (sp),
		.cpp      (cpp),
		.lv       (lv),
		.tos      (tos),
		.opc      (opc),
		.h        (h),
		.char_out (char_w),
		.line_end (line_end)
	);

endmodule

`default_nettype wire

// ==== reg_page_text.sv ====
//////////////////////////////
// Character source for the display. Maps page, line and column
// to one ASCII byte of "LBL:0xHHHHHHHH" and flags the end of line.
//////////////////////////////
`default_nettype none

`include "lcd_settings.svh"

module reg_page_text (
	input  lcd_pkg::page_t        page,
	input  logic                  line,
	input  lcd_pkg::col_t         col,
	input  logic [`LCD_REG_W-1:0] mdr,
	input  logic [`LCD_REG_W-1:0] mar,
	input  logic [`LCD_REG_W-1:0] pc,
	input  logic [`LCD_REG_W-1:0] mbr,
	input  logic [`LCD_REG_W-1:0] sp,
	input  logic [`LCD_REG_W-1:0] cpp,
	input  logic [`LCD_REG_W-1:0] lv,
	input  logic [`LCD_REG_W-1:0] tos,
	input  logic [`LCD_REG_W-1:0] opc,
	input  logic [`LCD_REG_W-1:0] h,
	output lcd_pkg::lcd_byte_t    char_out,
	output logic                  line_end
);

	import lcd_pkg::*;

	localparam lcd_byte_t chr_colon = 8'h3A;
	localparam lcd_byte_t chr_zero  = 8'h30;
	localparam lcd_byte_t chr_x     = 8'h78;
	localparam lcd_byte_t chr_a     = 8'h41;
	localparam lcd_byte_t chr_space = 8'h20;

	reg_word_u       sel;      // Register shown on this line
	logic [2:0][7:0] lbl;      // Label, first char in lbl[2]
	logic [1:0]      lbl_len;
	logic [4:0]      rel;      // Column relative to the colon
	logic [2:0]      dig_pos;
	logic [3:0]      nib;

	//////////////////////////////
	// Register and label select
	//////////////////////////////
	always_comb
	begin
		sel.word = mdr;
		lbl      = "MDR";
		lbl_len  = 2'd3;
		case ({page, line})
			{3'd0, 1'b1}:
			begin
				sel.word = mar;
				lbl      = "MAR";
			end
			{3'd1, 1'b0}:
			begin
				sel.word = pc;
				lbl      = "PC ";
				lbl_len  = 2'd2;
			end
			{3'd1, 1'b1}:
			begin
				sel.word = mbr;
				lbl      = "MBR";
			end
			{3'd2, 1'b0}:
			begin
				sel.word = sp;
				lbl      = "SP ";
				lbl_len  = 2'd2;
			end
			{3'd2, 1'b1}:
			begin
				sel.word = tos;
				lbl      = "TOS";
			end
			{3'd3, 1'b0}:
			begin
				sel.word = lv;
				lbl      = "LV ";
				lbl_len  = 2'd2;
			end
			{3'd3, 1'b1}:
			begin
				sel.word = cpp;
				lbl      = "CPP";
			end
			{3'd4, 1'b0}:
			begin
				sel.word = opc;
				lbl      = "OPC";
			end
			{3'd4, 1'b1}:
			begin
				sel.word = h;
				lbl      = "H  ";
				lbl_len  = 2'd1;
			end
			default: ; // MDR page
		endcase
	end

	//////////////////////////////
	// Character at the column
	//////////////////////////////
	assign rel     = {1'b0, col} - {3'b000, lbl_len};
	assign dig_pos = 3'(rel - 5'd3);
	assign nib     = sel.nib[3'(`LCD_DIGITS - 1) - dig_pos]; // MS nibble first

	always_comb
	begin
		line_end = 1'b0;
		char_out = chr_space;
		if (col < {2'b00, lbl_len})
			char_out = lbl[2'd2 - col[1:0]];
		else
		begin
			case (rel)
				5'd0: char_out = chr_colon;
				5'd1: char_out = chr_zero;
				5'd2: char_out = chr_x;
				default:
				begin
					if (rel > 5'd10)
						line_end = 1'b1; // Past the last digit
					else if (nib < 4'd10)
						char_out = chr_zero + {4'h0, nib};
					else
						char_out = chr_a + {4'h0, nib - 4'd10};
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the register LCD testbench with Verilator and runs it.
# Exits non-zero unless the log holds the pass line.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f files.f \
	--top-module tb_reg_lcd \
	-o sim_tb_reg_lcd

./obj_dir/sim_tb_reg_lcd | tee sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

// ==== tb_lcd_checks.sv ====
//////////////////////////////
// LCD bus monitor for the register LCD testbench. Rebuilds the
// transfer stream from the pins and checks it against a model.
//////////////////////////////
`default_nettype none

`include "lcd_settings.svh"

module tb_lcd_checks #(
	parameter int tick_div = 4
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic [2:0]         sw,
	input  logic [31:0]        mdr,
	input  logic [31:0]        mar,
	input  logic [31:0]        pc,
	input  logic [31:0]        mbr,
	input  logic [31:0]        sp,
	input  logic [31:0]        cpp,
	input  logic [31:0]        lv,
	input  logic [31:0]        tos,
	input  logic [31:0]        opc,
	input  logic [31:0]        h,
	input  logic               lcd_en,
	input  logic               lcd_rs,
	input  logic               lcd_rw,
	input  logic               lcd_on,
	input  lcd_pkg::lcd_byte_t lcd_data,
	output int                 errors,
	output int                 xfers,
	output int                 entries,
	output int                 clears,
	output int                 pulses,
	output logic               in_line2
);

	timeunit 1ns;
	timeprecision 100ps;

	import lcd_pkg::*;

	typedef struct packed {
		logic      is_char;
		logic      line;
		col_t      col;
		lcd_byte_t cmd;
	} item_t;

	string labels [5][2] = '{'{"MDR", "MAR"}, '{"PC", "MBR"}, '{"SP", "TOS"},
		'{"LV", "CPP"}, '{"OPC", "H"}};
	int    reg_idx [5][2] = '{'{0, 1}, '{2, 3}, '{4, 7}, '{6, 5}, '{8, 9}};

	item_t       exp_q[$];
	logic [31:0] regs_q [10]; // Register values one clock back
	logic [2:0]  sw_q;
	page_t       cur_page;
	page_t       last_page;
	logic        shown;
	logic        en_q;
	logic        rs_hold;
	lcd_byte_t   data_hold;
	int          hi_cnt;
	int          lo_cnt;

	task automatic report_mismatch(input string sig, input logic [31:0] got,
		input logic [31:0] want);
		$display("mismatch at %0d ns: %s got 0x%0h expected 0x%0h", $time, sig, got, want);
		errors++;
	endtask

	function automatic item_t cmd_item(input lcd_byte_t b);
		item_t it;
		it     = '0;
		it.cmd = b;
		return it;
	endfunction

	function automatic item_t char_item(input logic ln, input int c);
		item_t it;
		it         = '0;
		it.is_char = 1'b1;
		it.line    = ln;
		it.col     = col_t'(c);
		return it;
	endfunction

	function automatic lcd_byte_t hex_char(input logic [3:0] v);
		return (v < 4'd10) ? 8'h30 + 8'(v) : 8'h37 + 8'(v);
	endfunction

	// Label, colon, 0x, then digits MS first
	function automatic lcd_byte_t text_char(input page_t p, input logic ln, input int c);
		string     lbl;
		reg_word_u w;
		int        n;
		lbl    = labels[p][ln];
		n      = lbl.len();
		w.word = regs_q[reg_idx[p][ln]];
		if (c < n)
			return lbl[c];
		if (c == n)
			return 8'h3A;
		if (c == n + 1)
			return 8'h30;
		if (c == n + 2)
			return 8'h78;
		return hex_char(w.nib[7 - (c - n - 3)]);
	endfunction

	task automatic plan_refresh();
		page_t p;
		int    n;
		p = (sw_q < 3'd5) ? page_t'(sw_q) : page_t'(0); // Codes 5 to 7 show page 0
		if (!shown || p != last_page)
			exp_q.push_back(cmd_item(`LCD_CMD_CLEAR));
		shown     = 1'b1;
		last_page = p;
		cur_page  = p;
		exp_q.push_back(cmd_item(`LCD_CMD_HOME));
		for (int ln = 0; ln < 2; ln++)
		begin
			n = labels[p][ln].len() + 3 + `LCD_DIGITS;
			if (ln == 1)
				exp_q.push_back(cmd_item(`LCD_CMD_LINE2));
			for (int c = 0; c < n; c++)
				exp_q.push_back(char_item(ln[0], c));
		end
		exp_q.push_back(cmd_item(`LCD_CMD_ENTRY));
	endtask

	task automatic check_transfer();
		item_t     e;
		lcd_byte_t want;
		if (exp_q.size() == 0)
		begin
			$display("error at %0d ns: transfer 0x%h arrived when none was expected",
				$time, lcd_data);
			errors++;
			return;
		end
		e    = exp_q.pop_front();
		want = e.is_char ? text_char(cur_page, e.line, int'(e.col)) : e.cmd;
		assert (lcd_rs == e.is_char) else report_mismatch("lcd_rs", lcd_rs, e.is_char);
		assert (lcd_data == want) else report_mismatch("lcd_data", lcd_data, want);
		assert (lcd_on == (xfers != 0)) else report_mismatch("lcd_on", lcd_on, xfers != 0);
		if (!lcd_rs && lcd_data == `LCD_CMD_CLEAR && xfers >= 8)
			clears++; // Refresh clears only
		if (!lcd_rs && lcd_data == `LCD_CMD_ENTRY)
			entries++;
		if (!e.is_char && e.cmd == `LCD_CMD_LINE2)
			in_line2 = 1'b1;
		if (!e.is_char && e.cmd == `LCD_CMD_ENTRY)
		begin
			in_line2 = 1'b0;
			plan_refresh();
		end
	endtask

	initial
	begin
		errors   = 0;
		xfers    = 0;
		entries  = 0;
		clears   = 0;
		pulses   = 0;
		in_line2 = 1'b0;
	end

	//////////////////////////////
	// Sampled on the rising edge, pins settled
	//////////////////////////////
	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			exp_q.delete();
			for (int i = 0; i < 4; i++)
				exp_q.push_back(cmd_item(`LCD_CMD_FUNC));
			exp_q.push_back(cmd_item(`LCD_CMD_OFF));
			exp_q.push_back(cmd_item(`LCD_CMD_CLEAR));
			exp_q.push_back(cmd_item(`LCD_CMD_ON));
			exp_q.push_back(cmd_item(`LCD_CMD_ENTRY));
			shown     = 1'b0;
			last_page = '0;
			cur_page  = '0;
			en_q      = 1'b0;
			hi_cnt    = 0;
			lo_cnt    = 0;
			xfers     = 0;
			entries   = 0;
			clears    = 0;
			in_line2  = 1'b0;
		end
		else
		begin
			assert (lcd_rw == 1'b0) else report_mismatch("lcd_rw", lcd_rw, 0);
			if (lcd_en && !en_q)
			begin
				if (xfers != 0)
				begin
					assert (lo_cnt == tick_div)
					else report_mismatch("lcd_en low clocks", lo_cnt, tick_div);
				end
				check_transfer();
				xfers++;
				data_hold = lcd_data;
				rs_hold   = lcd_rs;
				hi_cnt    = 1;
			end
			else if (lcd_en)
			begin
				assert (lcd_data == data_hold)
				else report_mismatch("lcd_data", lcd_data, data_hold);
				assert (lcd_rs == rs_hold)
				else report_mismatch("lcd_rs", lcd_rs, rs_hold);
				hi_cnt++;
			end
			else if (en_q)
			begin
				assert (hi_cnt == tick_div)
				else report_mismatch("lcd_en high clocks", hi_cnt, tick_div);
				pulses++;
				lo_cnt = 1;
			end
			else
				lo_cnt++;
			en_q = lcd_en;
		end
		regs_q = '{mdr, mar, pc, mbr, sp, cpp, lv, tos, opc, h};
		sw_q   = sw;
	end

endmodule

`default_nettype wire

// ==== tb_reg_lcd.sv ====
//////////////////////////////
// Testbench top for the register LCD monitor. Drives pages and
// random register values, the bus monitor checks the pins.
//////////////////////////////
`default_nettype none

module tb_reg_lcd;

	timeunit 1ns;
	timeprecision 100ps;

	import lcd_pkg::*;

	localparam int tick_div    = 4;
	localparam int clk_ns      = 8;
	localparam int n_refresh   = 36; // Refreshes over all tests, rounded up
	localparam int n_xfers     = 2 * 8 + n_refresh * 32;
	localparam int watchdog_ns = n_xfers * 2 * tick_div * clk_ns * 2;

	logic        clk;
	logic        rst_n;
	logic [2:0]  sw;
	logic [31:0] mdr;
	logic [31:0] mar;
	logic [31:0] pc;
	logic [31:0] mbr;
	logic [31:0] sp;
	logic [31:0] cpp;
	logic [31:0] lv;
	logic [31:0] tos;
	logic [31:0] opc;
	logic [31:0] h;
	logic        lcd_en;
	logic        lcd_rs;
	logic        lcd_rw;
	logic        lcd_on;
	lcd_byte_t   lcd_data;

	int          mon_errors;
	int          mon_xfers;
	int          mon_entries;
	int          mon_clears;
	int          mon_pulses;
	logic        mon_line2;
	int          tb_errors;
	int          n_tests;
	int          n_failed;
	logic [15:0] lfsr;

	always #(clk_ns / 2) clk = ~clk;

	reg_lcd_top #(
		.tick_div (tick_div)
	) u_dut (
		.clk      (clk),
		.rst_n    (rst_n),
		.sw       (sw),
		.mdr      (mdr),
		.mar      (mar),
		.pc       (pc),
		.mbr      (mbr),
		.sp       (sp),
		.cpp      (cpp),
		.lv       (lv),
		.tos      (tos),
		.opc      (opc),
		.h        (h),
		.lcd_en   (lcd_en),
		.lcd_rs   (lcd_rs),
		.lcd_rw   (lcd_rw),
		.lcd_on   (lcd_on),
		.lcd_data (lcd_data)
	);

	tb_lcd_checks #(
		.tick_div (tick_div)
	) u_checks (
		.clk      (clk),
		.rst_n    (rst_n),
		.sw       (sw),
		.mdr      (mdr),
		.mar      (mar),
		.pc       (pc),
		.mbr      (mbr),
		.sp       (sp),
		.cpp      (cpp),
		.lv       (lv),
		.tos      (tos),
		.opc      (opc),
		.h        (h),
		.lcd_en   (lcd_en),
		.lcd_rs   (lcd_rs),
		.lcd_rw   (lcd_rw),
		.lcd_on   (lcd_on),
		.lcd_data (lcd_data),
		.errors   (mon_errors),
		.xfers    (mon_xfers),
		.entries  (mon_entries),
		.clears   (mon_clears),
		.pulses   (mon_pulses),
		.in_line2 (mon_line2)
	);

	// Taps 16, 14, 13, 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic random_word(output logic [31:0] w);
		w = '0;
		for (int i = 0; i < 32; i++)
		begin
			lfsr = lfsr_step(lfsr);
			w    = {w[30:0], lfsr[0]};
		end
	endtask

	task automatic load_registers();
		random_word(mdr);
		random_word(mar);
		random_word(pc);
		random_word(mbr);
		random_word(sp);
		random_word(cpp);
		random_word(lv);
		random_word(tos);
		random_word(opc);
		random_word(h);
	endtask

	function automatic int total_errors();
		return tb_errors + mon_errors;
	endfunction

	task automatic check_pin(input string name, input logic [7:0] got, input logic [7:0] want);
		assert (got === want)
		else
		begin
			$display("mismatch at %0d ns: %s got 0x%0h expected 0x%0h", $time, name, got, want);
			tb_errors++;
		end
	endtask

	task automatic check_idle();
		check_pin("lcd_en", 8'(lcd_en), 8'h00);
		check_pin("lcd_rs", 8'(lcd_rs), 8'h00);
		check_pin("lcd_rw", 8'(lcd_rw), 8'h00);
		check_pin("lcd_on", 8'(lcd_on), 8'h00);
		check_pin("lcd_data", lcd_data, 8'h00);
	endtask

	task automatic note_failure(input string what);
		$display("error at %0d ns: %s", $time, what);
		tb_errors++;
	endtask

	task automatic wait_entries(input int n);
		wait (mon_entries >= n);
		@(negedge clk);
	endtask

	task automatic finish_test(input string name, input int err_start);
		int errs;
		errs = total_errors() - err_start;
		n_tests++;
		if (errs == 0)
			$display("test %s: ok", name);
		else
		begin
			n_failed++;
			$display("test %s: failed with %0d errors", name, errs);
		end
	endtask

	task automatic pulse_reset();
		rst_n = 1'b0;
		repeat (2) @(negedge clk);
		check_idle(); // Pins cleared by reset
		rst_n = 1'b1;
	endtask

	//////////////////////////////
	// Tests, each starts just after an ENTRY
	//////////////////////////////
	task automatic init_test();
		int e0;
		e0 = total_errors();
		@(negedge clk);
		check_idle();
		wait (mon_xfers >= 8);
		@(negedge clk);
		assert (mon_entries == 1) else note_failure("init did not end with ENTRY");
		wait_entries(2);
		assert (mon_clears == 1) else note_failure("first refresh after reset did not clear");
		finish_test("reset and init", e0);
	endtask

	task automatic page_test(input int code);
		int e0;
		int n;
		int c0;
		int c1;
		e0 = total_errors();
		load_registers();
		sw = 3'(code);
		n  = mon_entries;
		wait_entries(n + 1); // New page decoded
		c0 = mon_clears;
		wait_entries(n + 2);
		assert (mon_clears == c0 + 1)
		else note_failure($sformatf("page %0d after a change did not clear", code));
		c1 = mon_clears;
		wait_entries(n + 3); // Same page again
		assert (mon_clears == c1)
		else note_failure($sformatf("repeat of page %0d cleared the display", code));
		finish_test($sformatf("page %0d text and clear", code), e0);
	endtask

	task automatic default_code_test();
		int e0;
		int n;
		int c0;
		e0 = total_errors();
		load_registers();
		sw = 3'd6;
		n  = mon_entries;
		wait_entries(n + 1);
		c0 = mon_clears;
		wait_entries(n + 2);
		for (int code = 5; code <= 7; code += 2)
		begin
			sw = 3'(code);
			n  = mon_entries;
			wait_entries(n + 2);
		end
		assert (mon_clears == c0) else note_failure("codes 5 to 7 after code 0 caused a CLEAR");
		finish_test("default codes", e0);
	endtask

	task automatic timing_test();
		int e0;
		int p0;
		e0 = total_errors();
		p0 = mon_pulses;
		wait_entries(mon_entries + 1);
		assert (mon_pulses > p0 + 10) else note_failure("too few enable pulses were seen");
		finish_test("pin timing", e0);
	endtask

	task automatic reset_test();
		int e0;
		e0 = total_errors();
		load_registers();
		wait (mon_line2);
		@(negedge clk);
		repeat (4 * tick_div) @(negedge clk); // A few characters into line 2
		assert (mon_line2) else note_failure("reset did not land inside line 2");
		pulse_reset();
		@(negedge clk);
		check_idle();
		wait (mon_xfers >= 8);
		@(negedge clk);
		assert (mon_entries == 1) else note_failure("init after reset did not end with ENTRY");
		wait_entries(2);
		assert (mon_clears == 1) else note_failure("first refresh after reset did not clear");
		finish_test("reset mid-refresh", e0);
	endtask

	initial
	begin
		clk       = 1'b0;
		rst_n     = 1'b0;
		sw        = 3'd0;
		lfsr      = 16'd33700;
		tb_errors = 0;
		n_tests   = 0;
		n_failed  = 0;
		load_registers();
		repeat (2) @(negedge clk);
		check_idle();
		rst_n = 1'b1;
		init_test();
		for (int i = 1; i <= 5; i++)
			page_test(i % 5); // Pages 1 to 4, then 0
		default_code_test();
		timing_test();
		reset_test();
		$display("tests %0d, failed %0d, errors %0d", n_tests, n_failed, total_errors());
		if (total_errors() == 0 && n_failed == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

	initial
	begin
		#(watchdog_ns);
		$display("error at %0d ns: watchdog expired before the tests finished", $time);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire
